//--- pepPkg.sv
// ====================
// Byte-wide subset of the Pep/9 encoding
// Only immediate mode is defined for non-unary opcodes
// ====================
package pepPkg;

    localparam int dataWidth = 8;
    localparam int regSelW = 1;     // 0 is A, 1 is X

    // Unary opcodes, specifier bits 7:1
    localparam logic [6:0] opNot = 7'h0C;
    localparam logic [6:0] opNeg = 7'h0D;
    localparam logic [6:0] opAsl = 7'h0E;
    localparam logic [6:0] opAsr = 7'h0F;
    localparam logic [6:0] opRol = 7'h10;
    localparam logic [6:0] opRor = 7'h11;

    // Non-unary opcodes, specifier bits 7:4
    localparam logic [3:0] opAdd = 4'd6;
    localparam logic [3:0] opSub = 4'd7;
    localparam logic [3:0] opAnd = 4'd8;
    localparam logic [3:0] opOr = 4'd9;
    localparam logic [3:0] opCpw = 4'd10;
    localparam logic [3:0] opLdw = 4'd12;

    localparam logic [2:0] amImmediate = 3'd0;

    typedef enum logic [3:0] {
        aluLoad,
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluNot,
        aluNeg,
        aluAsl,
        aluAsr,
        aluRol,
        aluRor
    } aluFuncT;

    typedef struct packed {
        logic [6:0] opcode;
        logic r;
    } unarySpecT;

    typedef struct packed {
        logic [3:0] opcode;
        logic r;
        logic [2:0] mode;   // aaa field
    } nonUnarySpecT;

    // Same byte, read one way or the other by decode
    typedef union packed {
        unarySpecT unary;
        nonUnarySpecT nonUnary;
    } instrSpecT;

    typedef struct packed {
        logic n;
        logic z;
        logic v;
        logic c;
    } statusT;

endpackage

//--- pepIfs.sv
// ====================
// Stage links use valid/ready, payload held while stalled
// Register port reads are combinational
// ====================
`timescale 1ns/100ps

interface fetchIf;
    import pepPkg::*;

    logic valid;
    logic ready;
    instrSpecT spec;
    logic [dataWidth-1:0] operand;

    modport producer (output valid, spec, operand, input ready);
    modport consumer (input valid, spec, operand, output ready);
endinterface

interface aluCmdIf;
    import pepPkg::*;

    logic valid;
    logic ready;
    aluFuncT func;
    logic [regSelW-1:0] regSel;
    logic writeBack;    // Low for compare
    logic [dataWidth-1:0] operand;

    modport producer (output valid, func, regSel, writeBack, operand, input ready);
    modport consumer (input valid, func, regSel, writeBack, operand, output ready);
endinterface

interface regPortIf;
    import pepPkg::*;

    logic [regSelW-1:0] rdSel;
    logic [dataWidth-1:0] rdData;
    logic wrEn;
    logic [regSelW-1:0] wrSel;
    logic [dataWidth-1:0] wrData;
    logic flagsWrEn;
    statusT flagsNext;
    statusT flags;

    modport exec (output rdSel, wrEn, wrSel, wrData, flagsWrEn, flagsNext,
                  input rdData, flags);
    modport regFile (input rdSel, wrEn, wrSel, wrData, flagsWrEn, flagsNext,
                     output rdData, flags);
endinterface

//--- instrFetch.sv
// ====================
// One-entry input register for specifier and operand
// ====================
`timescale 1ns/100ps

module instrFetch (
    input  logic Sysclk,
    input  logic resetbar,
    input  logic instrValid,
    input  pepPkg::instrSpecT instrSpec,
    input  logic [pepPkg::dataWidth-1:0] instrOperand,
    output logic instrReady,
    fetchIf.producer fetchOut
);
    import pepPkg::*;

    logic slotValid;
    instrSpecT specReg;
    logic [dataWidth-1:0] operandReg;

    // Accept when empty or when decode takes the current entry
    assign instrReady = !slotValid || fetchOut.ready;

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
            slotValid <= 1'b0;
        else if (instrReady)
            slotValid <= instrValid;
    end

    always_ff @(posedge Sysclk)
    begin
        if (instrValid && instrReady)
        begin
            specReg <= instrSpec;
            operandReg <= instrOperand;
        end
    end

    assign fetchOut.valid = slotValid;
    assign fetchOut.spec = specReg;
    assign fetchOut.operand = operandReg;

endmodule

//--- instrDecode.sv
// ====================
// Unsupported specifiers and non-immediate modes are
// accepted and dropped without a command
// ====================
`timescale 1ns/100ps

module instrDecode (
    input  logic Sysclk,
    input  logic resetbar,
    fetchIf.consumer fetchIn,
    aluCmdIf.producer cmdOut
);
    import pepPkg::*;

    logic isUnary;
    logic supported;
    aluFuncT funcDec;
    logic [regSelW-1:0] regSelDec;
    logic writeBackDec;

    logic cmdValid;
    aluFuncT funcReg;
    logic [regSelW-1:0] regSelReg;
    logic writeBackReg;
    logic [dataWidth-1:0] operandReg;

    // All opcodes below ADD are treated as unary here
    assign isUnary = fetchIn.spec.nonUnary.opcode < opAdd;

    always_comb
    begin
        supported = 1'b1;
        funcDec = aluLoad;
        writeBackDec = 1'b1;
        if (isUnary)
        begin
            regSelDec = fetchIn.spec.unary.r;
            case (fetchIn.spec.unary.opcode)
                opNot: funcDec = aluNot;
                opNeg: funcDec = aluNeg;
                opAsl: funcDec = aluAsl;
                opAsr: funcDec = aluAsr;
                opRol: funcDec = aluRol;
                opRor: funcDec = aluRor;
                default: supported = 1'b0;
            endcase
        end
        else
        begin
            regSelDec = fetchIn.spec.nonUnary.r;
            case (fetchIn.spec.nonUnary.opcode)
                opAdd: funcDec = aluAdd;
                opSub: funcDec = aluSub;
                opAnd: funcDec = aluAnd;
                opOr:  funcDec = aluOr;
                opCpw:
                begin
                    funcDec = aluSub;
                    writeBackDec = 1'b0;    // Flags only
                end
                opLdw: funcDec = aluLoad;
                default: supported = 1'b0;
            endcase
            if (fetchIn.spec.nonUnary.mode != amImmediate)
                supported = 1'b0;
        end
    end

    assign fetchIn.ready = !cmdValid || cmdOut.ready;

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
            cmdValid <= 1'b0;
        else if (fetchIn.ready)
            cmdValid <= fetchIn.valid && supported;
    end

    always_ff @(posedge Sysclk)
    begin
        if (fetchIn.valid && fetchIn.ready && supported)
        begin
            funcReg <= funcDec;
            regSelReg <= regSelDec;
            writeBackReg <= writeBackDec;
            operandReg <= fetchIn.operand;
        end
    end

    assign cmdOut.valid = cmdValid;
    assign cmdOut.func = funcReg;
    assign cmdOut.regSel = regSelReg;
    assign cmdOut.writeBack = writeBackReg;
    assign cmdOut.operand = operandReg;

endmodule

//--- aluCore.sv
// ====================
// Purely combinational, N and Z always follow y
// Rotates go through the incoming C flag
// ====================
`timescale 1ns/100ps

module aluCore (
    input  pepPkg::aluFuncT func,
    input  logic [pepPkg::dataWidth-1:0] a,
    input  logic [pepPkg::dataWidth-1:0] b,
    input  pepPkg::statusT flagsIn,
    output logic [pepPkg::dataWidth-1:0] y,
    output pepPkg::statusT flagsOut
);
    import pepPkg::*;

    localparam int msb = dataWidth - 1;

    logic [msb:0] addA;
    logic [msb:0] addB;
    logic addCin;
    logic [dataWidth:0] sum;
    logic addOvf;

    // One adder shared by add, sub and neg
    always_comb
    begin
        addA = a;
        addB = b;
        addCin = 1'b0;
        case (func)
            aluSub:
            begin
                addB = ~b;
                addCin = 1'b1;
            end
            aluNeg:
            begin
                addA = '0;      // 0 - a
                addB = ~a;
                addCin = 1'b1;
            end
            default: ;
        endcase
    end

    assign sum = {1'b0, addA} + {1'b0, addB} + {{dataWidth{1'b0}}, addCin};
    assign addOvf = (addA[msb] == addB[msb]) && (sum[msb] != addA[msb]);

    always_comb
    begin
        y = b;
        flagsOut.v = flagsIn.v;
        flagsOut.c = flagsIn.c;
        case (func)
            aluLoad: y = b;
            aluAdd, aluSub, aluNeg:
            begin
                y = sum[msb:0];
                flagsOut.v = addOvf;
                flagsOut.c = sum[dataWidth];
            end
            aluAnd: y = a & b;
            aluOr:  y = a | b;
            aluNot: y = ~a;
            aluAsl:
            begin
                y = {a[msb-1:0], 1'b0};
                flagsOut.v = a[msb] ^ a[msb-1];    // Sign changed
                flagsOut.c = a[msb];
            end
            aluAsr:
            begin
                y = {a[msb], a[msb:1]};
                flagsOut.c = a[0];
            end
            aluRol:
            begin
                y = {a[msb-1:0], flagsIn.c};
                flagsOut.c = a[msb];
            end
            aluRor:
            begin
                y = {flagsIn.c, a[msb:1]};
                flagsOut.c = a[0];
            end
            default: ;
        endcase
        flagsOut.n = y[msb];
        flagsOut.z = (y == '0);
    end

endmodule

//--- cpuRegs.sv
// ====================
// A, X and NZVC, all cleared by reset
// ====================
`timescale 1ns/100ps

module cpuRegs (
    input  logic Sysclk,
    input  logic resetbar,
    regPortIf.regFile regPort
);
    import pepPkg::*;

    logic [dataWidth-1:0] regA;
    logic [dataWidth-1:0] regX;
    statusT flagsReg;

    assign regPort.rdData = regPort.rdSel[0] ? regX : regA;
    assign regPort.flags = flagsReg;

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
        begin
            regA <= '0;
            regX <= '0;
            flagsReg <= '0;
        end
        else
        begin
            if (regPort.wrEn && !regPort.wrSel[0])
                regA <= regPort.wrData;
            if (regPort.wrEn && regPort.wrSel[0])
                regX <= regPort.wrData;
            if (regPort.flagsWrEn)
                flagsReg <= regPort.flagsNext;
        end
    end

endmodule

//--- execStage.sv
// ====================
// Register read, ALU and writeback happen on the command transfer
// Output holds while resultReady is low
// ====================
`timescale 1ns/100ps

module execStage (
    input  logic Sysclk,
    input  logic resetbar,
    aluCmdIf.consumer cmdIn,
    regPortIf.exec regPort,
    output logic resultValid,
    input  logic resultReady,
    output logic [pepPkg::dataWidth-1:0] result,
    output pepPkg::statusT resultFlags
);
    import pepPkg::*;

    logic xfer;
    logic [dataWidth-1:0] aluY;
    statusT aluFlags;

    assign cmdIn.ready = !resultValid || resultReady;
    assign xfer = cmdIn.valid && cmdIn.ready;

    assign regPort.rdSel = cmdIn.regSel;

    aluCore alu0 (
        .func(cmdIn.func),
        .a(regPort.rdData),
        .b(cmdIn.operand),     // Immediate operand
        .flagsIn(regPort.flags),
        .y(aluY),
        .flagsOut(aluFlags)
    );

    // Commit in the same edge as the result register
    assign regPort.wrEn = xfer && cmdIn.writeBack;
    assign regPort.wrSel = cmdIn.regSel;
    assign regPort.wrData = aluY;
    assign regPort.flagsWrEn = xfer;
    assign regPort.flagsNext = aluFlags;

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
            resultValid <= 1'b0;
        else if (cmdIn.ready)
            resultValid <= cmdIn.valid;
    end

    always_ff @(posedge Sysclk)
    begin
        if (xfer)
        begin
            result <= aluY;
            resultFlags <= aluFlags;
        end
    end

endmodule

//--- pepCpu.sv
// ====================
// Three-stage pipeline, one result per executed instruction
// Unsupported specifiers give no result
// ====================
`timescale 1ns/100ps

module pepCpu (
    input  logic Sysclk,
    input  logic resetbar,
    input  logic instrValid,
    output logic instrReady,
    input  pepPkg::instrSpecT instrSpec,
    input  logic [pepPkg::dataWidth-1:0] instrOperand,
    output logic resultValid,
    input  logic resultReady,
    output logic [pepPkg::dataWidth-1:0] result,
    output pepPkg::statusT resultFlags
);

    fetchIf fetchBus ();
    aluCmdIf cmdBus ();
    regPortIf regBus ();

    instrFetch fetch0 (
        .Sysclk(Sysclk),
        .resetbar(resetbar),
        .instrValid(instrValid),
        .instrSpec(instrSpec),
        .instrOperand(instrOperand),
        .instrReady(instrReady),
        .fetchOut(fetchBus.producer)
    );

    instrDecode decode0 (
        .Sysclk(Sysclk),
        .resetbar(resetbar),
        .fetchIn(fetchBus.consumer),
        .cmdOut(cmdBus.producer)
    );

    execStage exec0 (
        .Sysclk(Sysclk),
        .resetbar(resetbar),
        .cmdIn(cmdBus.consumer),
        .regPort(regBus.exec),
        .resultValid(resultValid),
        .resultReady(resultReady),
        .result(result),
        .resultFlags(resultFlags)
    );

    cpuRegs regs0 (
        .Sysclk(Sysclk),
        .resetbar(resetbar),
        .regPort(regBus.regFile)
    );

endmodule

//--- tbRefModel.svh
// ====================
// Reference model of A, X and NZVC, included inside the testbench module
// Applies an instruction when the input accepts it and queues the expected result
// ====================
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [7:0] mdlA = 8'h00;
logic [7:0] mdlX = 8'h00;
logic mdlN = 1'b0;
logic mdlZ = 1'b0;
logic mdlV = 1'b0;
logic mdlC = 1'b0;

logic [7:0] expResQ[$];
logic [3:0] expFlagsQ[$];     // N Z V C, N in bit 3
string expNameQ[$];

task automatic modelExecute(input logic [7:0] spec, input logic [7:0] opnd,
                            input string name);
    logic unary;
    logic rSel;
    logic known;
    logic keep;
    logic [7:0] src;
    logic [7:0] y;
    logic [8:0] wide;
    int sWide;
    unary = spec[7:4] < 4'd6;
    rSel = unary ? spec[0] : spec[3];
    src = rSel ? mdlX : mdlA;
    known = 1'b1;
    keep = 1'b1;
    y = 8'h00;
    if (unary)
    begin
        case (spec[7:1])
            7'h0C: y = ~src;
            7'h0D:
            begin
                y = 8'h00 - src;
                mdlV = src == 8'h80;    // Only -128 overflows
                mdlC = src == 8'h00;
            end
            7'h0E:
            begin
                y = {src[6:0], 1'b0};
                mdlV = y[7] != src[7];
                mdlC = src[7];
            end
            7'h0F:
            begin
                y = {src[7], src[7:1]};
                mdlC = src[0];
            end
            7'h10:
            begin
                y = {src[6:0], mdlC};   // Old C shifts in
                mdlC = src[7];
            end
            7'h11:
            begin
                y = {mdlC, src[7:1]};
                mdlC = src[0];
            end
            default: known = 1'b0;
        endcase
    end
    else if (spec[2:0] != 3'b000)
        known = 1'b0;   // Immediate mode only
    else
    begin
        case (spec[7:4])
            4'd6:
            begin
                wide = {1'b0, src} + {1'b0, opnd};
                y = wide[7:0];
                mdlC = wide[8];
                sWide = int'($signed(src)) + int'($signed(opnd));
                mdlV = (sWide > 127) || (sWide < -128);
            end
            4'd7, 4'd10:
            begin
                y = src - opnd;
                mdlC = src >= opnd;     // Carry set when no borrow
                sWide = int'($signed(src)) - int'($signed(opnd));
                mdlV = (sWide > 127) || (sWide < -128);
                keep = spec[7:4] == 4'd7;
            end
            4'd8: y = src & opnd;
            4'd9: y = src | opnd;
            4'd12: y = opnd;
            default: known = 1'b0;
        endcase
    end
    if (known)
    begin
        mdlN = y[7];
        mdlZ = y == 8'h00;
        if (keep && rSel)
            mdlX = y;
        if (keep && !rSel)
            mdlA = y;
        expResQ.push_back(y);
        expFlagsQ.push_back({mdlN, mdlZ, mdlV, mdlC});
        expNameQ.push_back(name);
    end
endtask

`endif

//--- pepCpuTb.sv
// ====================
// Random stimulus from a fixed seed, random result back-pressure
// Stops at the first failed check, watchdog scales with instruction count
// ====================
`timescale 1ns/100ps

module pepCpuTb;
    import pepPkg::*;

    localparam int clkPeriod = 8;
    localparam int resetCycles = 16;
    localparam int cycleBudget = 16;    // Cycles per instruction, stalls included

    logic Sysclk = 1'b0;
    logic resetbar = 1'b0;
    logic instrValid = 1'b0;
    logic instrReady;
    instrSpecT instrSpec = '0;
    logic [7:0] instrOperand = 8'h00;
    logic resultValid;
    logic resultReady = 1'b0;
    logic [7:0] result;
    statusT resultFlags;
    logic [3:0] actFlags;

    integer seed = 32'h32b7_312b;

    logic [7:0] stimSpecQ[$];
    logic [7:0] stimOpndQ[$];
    string stimNameQ[$];
    int numInstr = 0;
    int sendIdx = 0;
    int gotCount = 0;
    int resetEdges = 0;
    logic holdPending = 1'b0;
    logic [7:0] heldResult;
    logic [3:0] heldFlags;

    `include "tbRefModel.svh"

    pepCpu dut0 (
        .Sysclk(Sysclk),
        .resetbar(resetbar),
        .instrValid(instrValid),
        .instrReady(instrReady),
        .instrSpec(instrSpec),
        .instrOperand(instrOperand),
        .resultValid(resultValid),
        .resultReady(resultReady),
        .result(result),
        .resultFlags(resultFlags)
    );

    assign actFlags = resultFlags;

    always #(clkPeriod / 2) Sysclk = ~Sysclk;

    function automatic logic [7:0] randByte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic int randBelow(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r[15:0]) % n;
    endfunction

    // Index 0 LDW, 1..5 ADD SUB AND OR CPW, 6..11 NOT NEG ASL ASR ROL ROR
    function automatic logic [7:0] specOf(input int idx, input logic r);
        logic [7:0] s;
        case (idx)
            0: s = 8'hC0;
            1: s = 8'h60;
            2: s = 8'h70;
            3: s = 8'h80;
            4: s = 8'h90;
            5: s = 8'hA0;
            6: s = 8'h18;
            7: s = 8'h1A;
            8: s = 8'h1C;
            9: s = 8'h1E;
            10: s = 8'h20;
            11: s = 8'h22;
            default: s = 8'h00;
        endcase
        if (idx < 6)
            s[3] = r;   // r bit of the non-unary view
        else
            s[0] = r;
        return s;
    endfunction

    task automatic addInstr(input logic [7:0] spec, input logic [7:0] opnd, input string name);
        stimSpecQ.push_back(spec);
        stimOpndQ.push_back(opnd);
        stimNameQ.push_back(name);
    endtask

    // Dropped specifier, then OR 0 on both registers shows nothing moved
    task automatic addUnsupported(input logic [7:0] spec);
        addInstr(spec, randByte(), "unsup");
        addInstr(specOf(4, 1'b0), 8'h00, "unsupKeepA");
        addInstr(specOf(4, 1'b1), 8'h00, "unsupKeepX");
    endtask

    task automatic buildStimulus();
        int i;
        logic r;
        logic [7:0] s;
        addInstr(specOf(0, 1'b0), randByte(), "ldwA");
        addInstr(specOf(0, 1'b1), randByte(), "ldwX");
        addInstr(specOf(0, 1'b1), 8'h00, "ldwZero");
        for (i = 0; i < 32; i++)
            addInstr(specOf(1 + i % 4, i[3]), randByte(), "aluDep");
        for (i = 0; i < 6; i++)
        begin
            addInstr(specOf(5, i[0]), randByte(), "cpw");
            addInstr(specOf(4, i[0]), 8'h00, "cpwKeep");
        end
        for (i = 0; i < 48; i++)
        begin
            r = ((i / 6) % 2) == 1;
            if (i % 6 == 0)
                addInstr(specOf(0, r), randByte(), "unaryLoad");
            addInstr(specOf(6 + i % 6, r), randByte(), "unary");
        end
        addUnsupported(8'h00);
        addUnsupported(8'h61);      // ADD, mode 1
        addUnsupported(8'h6B);
        addUnsupported(8'hB0);
        addUnsupported(8'hE0);      // Store
        addUnsupported(8'h04);
        addUnsupported(8'hC9);
        addUnsupported(8'h24);
        addUnsupported(8'hFF);
        for (i = 0; i < 240; i++)
        begin
            s = randByte();
            if (randBelow(4) != 0)
                s = specOf(randBelow(12), s[0]);
            addInstr(s, randByte(), "random");
        end
        numInstr = stimSpecQ.size();
    endtask

    task automatic abortRun(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic failMismatch(input string name, input logic [7:0] expRes,
                                input logic [3:0] expFl, input logic [7:0] actRes,
                                input logic [3:0] actFl);
        $display("MISMATCH %s: expected result %02h nzvc %04b, actual result %02h nzvc %04b",
                 name, expRes, expFl, actRes, actFl);
        $display("Test FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    // Input driver and result back-pressure, model runs on acceptance
    always @(posedge Sysclk)
    begin
        if (!resetbar)
        begin
            instrValid <= 1'b0;
            resultReady <= 1'b0;
        end
        else
        begin
            if (instrValid && instrReady)
            begin
                modelExecute(stimSpecQ[sendIdx], stimOpndQ[sendIdx], stimNameQ[sendIdx]);
                sendIdx++;
            end
            if (!instrValid || instrReady)  // Offer stays put while stalled
            begin
                if (sendIdx < numInstr && randBelow(4) != 0)
                begin
                    instrValid <= 1'b1;
                    instrSpec <= stimSpecQ[sendIdx];
                    instrOperand <= stimOpndQ[sendIdx];
                end
                else
                    instrValid <= 1'b0;
            end
            resultReady <= randBelow(3) != 0;
        end
    end

    // Scoreboard
    always @(posedge Sysclk)
    begin
        if (!resetbar)
        begin
            resetEdges++;
            if (resetEdges > 1)
                assert (resultValid === 1'b0)
                    else abortRun("resultValid is not low during reset");
            holdPending = 1'b0;
        end
        else
        begin
            if (holdPending)
                assert (resultValid === 1'b1 && result === heldResult && actFlags === heldFlags)
                    else abortRun("result dropped or changed while resultReady was low");
            if (resultValid && resultReady)
            begin
                assert (expResQ.size() != 0)
                    else abortRun("result transfer with no expected result left");
                assert (result === expResQ[0] && actFlags === expFlagsQ[0])
                    else failMismatch(expNameQ[0], expResQ[0], expFlagsQ[0], result, actFlags);
                void'(expResQ.pop_front());
                void'(expFlagsQ.pop_front());
                void'(expNameQ.pop_front());
                gotCount++;
            end
            holdPending = resultValid && !resultReady;
            heldResult = result;
            heldFlags = actFlags;
        end
    end

    initial
    begin : watchdog
        int limitNs;
        wait (numInstr > 0);
        limitNs = (resetCycles + numInstr * cycleBudget) * clkPeriod;
        #(limitNs);
        $display("Watchdog expired after %0d ns, %0d of %0d instructions sent",
                 limitNs, sendIdx, numInstr);
        $display("Test FAILED");
        $fatal(1, "watchdog timeout");
    end

    initial
    begin
        buildStimulus();
        repeat (resetCycles) @(posedge Sysclk);
        resetbar <= 1'b1;
        while (sendIdx < numInstr || expResQ.size() != 0)
            @(posedge Sysclk);
        repeat (20) @(posedge Sysclk);    // Any late extra result hits the scoreboard
        $display("%0d instructions, %0d results checked", numInstr, gotCount);
        $display("Test OK");
        $finish;
    end

endmodule

//--- build.f
+incdir+.
pepPkg.sv
pepIfs.sv
instrFetch.sv
instrDecode.sv
aluCore.sv
cpuRegs.sv
execStage.sv
pepCpu.sv
pepCpuTb.sv

//--- runSim.sh
#!/bin/sh
# Compile and run the pepCpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module pepCpuTb -f build.f -o pepCpuSim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/pepCpuSim > sim.log 2>&1
runStatus=$?
cat sim.log

if grep -q "Test FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $runStatus -ne 0 ]; then
    echo "Simulator exited with status $runStatus"
    exit 1
fi
echo "Simulation passed"
exit 0
